/* hw/pf_macros.svh */
// Global sizes; PF_NUM_SLICES must be a power of two no larger than 2**PF_ID_BITS
`ifndef PF_MACROS_SVH
`define PF_MACROS_SVH

// Request fields
`define PF_ADDR_BITS  32
`define PF_LEN_BITS   8
`define PF_ID_BITS    4

// Slices are picked by the low ID bits
`define PF_NUM_SLICES 4

// Tag queue depth is 2**PF_LOG_QUEUE per slice
`define PF_LOG_QUEUE  3

// Watchdog divider count width
`define PF_WDOG_BITS  10

`endif

/* hw/pf_pkg.sv */
// Request and state types shared by all blocks; sizes come from pf_macros.svh
`default_nettype none

`include "pf_macros.svh"

package pf_pkg;

    // One AR read request
    typedef struct packed {
        logic [`PF_ADDR_BITS-1:0] addr;
        logic [`PF_LEN_BITS-1:0]  len;
        logic [`PF_ID_BITS-1:0]   id;
    } ar_req_t;

    // Per-slice stream learning states
    typedef enum logic [1:0] {
        ST_IDLE,     // No context
        ST_ARM,      // First request seen, waiting for stride
        ST_ACTIVE,   // Stride learned, prefetching
        ST_CLEANUP   // Dropping tags, back to idle next cycle
    } slice_state_t;

endpackage

`default_nettype wire

/* hw/watchdog_timer.sv */
// Tick every wdog_div+1 cycles; timeout stays high until the next kick
`default_nettype none
`timescale 1ns/1ps

`include "pf_macros.svh"

module watchdog_timer (
    input  logic                     clk,
    input  logic                     resetN,
    input  logic [`PF_WDOG_BITS-1:0] wdog_div,
    input  logic                     kick,
    output logic                     timeout
);

    logic [`PF_WDOG_BITS-1:0] cnt;
    logic                     tick;
    logic                     armed;   // One tick already passed without a kick

    assign tick = (cnt == '0);

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            cnt     <= '0;
            armed   <= 1'b0;
            timeout <= 1'b0;
        end else begin
            cnt <= tick ? wdog_div : cnt - 1'b1;   // Reload on terminal count

            if (kick) begin
                armed   <= 1'b0;
                timeout <= 1'b0;
            end else if (tick) begin
                armed <= 1'b1;
                if (armed)
                    timeout <= 1'b1;   // Second quiet tick
            end
        end
    end

endmodule

`default_nettype wire

/* hw/ar_dispatch.sv */
// Single holding register, so the slave AR side takes at most one request every two cycles
`default_nettype none
`timescale 1ns/1ps

`include "pf_macros.svh"

module ar_dispatch (
    input  logic                      clk,
    input  logic                      resetN,
    input  logic                      s_ar_valid,
    input  pf_pkg::ar_req_t           s_ar,
    input  logic [`PF_NUM_SLICES-1:0] busy,
    output logic                      s_ar_ready,
    output logic [`PF_NUM_SLICES-1:0] dmd_strobe,
    output pf_pkg::ar_req_t           dmd_req
);
    import pf_pkg::*;

    localparam int SEL_BITS = $clog2(`PF_NUM_SLICES);

    ar_req_t             hold_req;
    logic                hold_valid;
    logic [SEL_BITS-1:0] sel;
    logic                deliver;

    assign sel        = hold_req.id[SEL_BITS-1:0];   // Slice by low ID bits
    assign deliver    = hold_valid && !busy[sel];
    assign s_ar_ready = !hold_valid;
    assign dmd_req    = hold_req;

    // Strobe stays up while the target slice is busy
    always_comb begin
        dmd_strobe = '0;
        if (hold_valid)
            dmd_strobe[sel] = 1'b1;
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            hold_valid <= 1'b0;
        end else if (s_ar_valid && s_ar_ready) begin
            hold_valid <= 1'b1;
        end else if (deliver) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (s_ar_valid && s_ar_ready)
            hold_req <= s_ar;
    end

endmodule

`default_nettype wire

/* hw/prefetch_slice.sv */
// One stream per slice; bursts of half the tag queue or longer are forwarded, never learned
`default_nettype none
`timescale 1ns/1ps

`include "pf_macros.svh"

module prefetch_slice (
    input  logic                     clk,
    input  logic                     resetN,
    input  logic                     flush,
    input  logic                     dmd_strobe,
    input  pf_pkg::ar_req_t          dmd_req,
    input  logic                     grant,
    input  logic [`PF_ADDR_BITS-1:0] bar,
    input  logic [`PF_ADDR_BITS-1:0] limit,
    input  logic [`PF_LOG_QUEUE:0]   window_size,
    input  logic [`PF_WDOG_BITS-1:0] wdog_div,
    output logic                     req_valid,
    output pf_pkg::ar_req_t          req,
    output logic                     busy,
    output logic                     hit,
    output pf_pkg::ar_req_t          hit_req
);
    import pf_pkg::*;

    localparam int DEPTH = 1 << `PF_LOG_QUEUE;

    slice_state_t state;
    slice_state_t state_next;

    // Learned stream context
    logic [`PF_ID_BITS-1:0]   ctx_id;
    logic [`PF_LEN_BITS-1:0]  ctx_len;
    logic [`PF_ADDR_BITS-1:0] stride;
    logic [`PF_ADDR_BITS-1:0] last_addr;
    logic [`PF_ADDR_BITS-1:0] pf_addr;     // Next address to prefetch
    logic [`PF_ADDR_BITS-1:0] stride_smp;  // Stride seen by the current demand

    // Tags of issued prefetches
    logic [DEPTH-1:0]         tag_valid;
    logic [`PF_ADDR_BITS-1:0] tag_addr [DEPTH];
    logic [`PF_LOG_QUEUE:0]   tag_cnt;
    logic [`PF_LOG_QUEUE-1:0] free_idx;
    logic [`PF_LOG_QUEUE-1:0] match_idx;
    logic                     tag_match;

    // Forwarded demand waiting for the arbiter
    logic    dmd_pend;
    ar_req_t dmd_hold;
    ar_req_t pf_req;

    logic take;
    logic learnable;
    logic ctx_miss;
    logic drop;
    logic first;
    logic learn;
    logic hit_now;
    logic pf_valid;
    logic pf_take;
    logic timeout;
    logic kick;

    watchdog_timer u_wdog (
        .clk      (clk),
        .resetN   (resetN),
        .wdog_div (wdog_div),
        .kick     (kick),
        .timeout  (timeout)
    );

    assign take       = dmd_strobe && !busy;
    assign learnable  = dmd_req.len < `PF_LEN_BITS'(DEPTH / 2);
    assign stride_smp = dmd_req.addr - last_addr;
    assign kick       = take || (state == ST_IDLE);   // No timeout without a context

    // Any context break on a demand
    assign ctx_miss = (dmd_req.id != ctx_id) || (dmd_req.len != ctx_len) || !learnable
                      || (state == ST_ACTIVE && stride_smp != stride);
    assign drop     = flush || timeout || (take && ctx_miss);

    assign first   = (state == ST_IDLE) && take && learnable;
    assign learn   = (state == ST_ARM) && take && !drop && (stride_smp != '0);
    assign hit_now = (state == ST_ACTIVE) && take && !drop && tag_match;

    // Tag count, first free slot and address match
    always_comb begin
        tag_cnt   = '0;
        tag_match = 1'b0;
        match_idx = '0;
        free_idx  = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin   // Lowest index wins
            tag_cnt = tag_cnt + {`PF_LOG_QUEUE'(0), tag_valid[i]};
            if (!tag_valid[i])
                free_idx = `PF_LOG_QUEUE'(i);
            if (tag_valid[i] && tag_addr[i] == dmd_req.addr) begin
                tag_match = 1'b1;
                match_idx = `PF_LOG_QUEUE'(i);
            end
        end
    end

    assign pf_valid = (state == ST_ACTIVE) && (tag_cnt < window_size) && !(&tag_valid)
                      && (pf_addr >= bar) && (pf_addr <= limit);

    assign pf_req    = '{addr: pf_addr, len: ctx_len, id: ctx_id};
    assign req_valid = dmd_pend || pf_valid;
    assign req       = dmd_pend ? dmd_hold : pf_req;   // Demand miss goes first
    assign pf_take   = grant && !dmd_pend;
    assign busy      = dmd_pend || (state == ST_CLEANUP);

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (first)
                    state_next = ST_ARM;
            end
            ST_ARM: begin
                if (drop)
                    state_next = ST_CLEANUP;
                else if (learn)
                    state_next = ST_ACTIVE;
            end
            ST_ACTIVE: begin
                if (drop)
                    state_next = ST_CLEANUP;
            end
            default: state_next = ST_IDLE;   // Cleanup lasts one cycle
        endcase
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            state     <= ST_IDLE;
            dmd_pend  <= 1'b0;
            hit       <= 1'b0;
            tag_valid <= '0;
        end else begin
            state <= state_next;
            hit   <= hit_now;

            if (take && !hit_now)
                dmd_pend <= 1'b1;
            else if (grant && dmd_pend)
                dmd_pend <= 1'b0;

            if (state == ST_CLEANUP) begin
                tag_valid <= '0;
            end else begin
                if (pf_take)
                    tag_valid[free_idx] <= 1'b1;
                if (hit_now)
                    tag_valid[match_idx] <= 1'b0;   // Pop on hit
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take)
            last_addr <= dmd_req.addr;
        if (take && !hit_now)
            dmd_hold <= dmd_req;
        if (hit_now)
            hit_req <= dmd_req;
        if (pf_take)
            tag_addr[free_idx] <= pf_addr;

        if (first) begin
            ctx_id  <= dmd_req.id;
            ctx_len <= dmd_req.len;
        end

        if (learn) begin
            stride  <= stride_smp;
            pf_addr <= dmd_req.addr + stride_smp;   // Start one stride ahead
        end else if (pf_take) begin
            pf_addr <= pf_addr + stride;
        end
    end

endmodule

`default_nettype wire

/* hw/ar_arbiter.sv */
// Round-robin over the slices; a grant is given only when the output register can take it
`default_nettype none
`timescale 1ns/1ps

`include "pf_macros.svh"

module ar_arbiter (
    input  logic                                  clk,
    input  logic                                  resetN,
    input  logic [`PF_NUM_SLICES-1:0]             req_valid,
    input  pf_pkg::ar_req_t [`PF_NUM_SLICES-1:0]  req,
    input  logic                                  m_ar_ready,
    output logic [`PF_NUM_SLICES-1:0]             grant,
    output logic                                  m_ar_valid,
    output pf_pkg::ar_req_t                       m_ar
);
    import pf_pkg::*;

    localparam int N        = `PF_NUM_SLICES;
    localparam int SEL_BITS = $clog2(N);

    logic [SEL_BITS-1:0] ptr;    // Last winner
    logic [SEL_BITS-1:0] cand;
    logic [SEL_BITS-1:0] win;
    logic                found;
    logic                free;

    assign free = !m_ar_valid || m_ar_ready;

    // Search starts right after the last winner, which is checked last
    always_comb begin
        found = 1'b0;
        win   = '0;
        cand  = '0;
        for (int k = 1; k <= N; k++) begin
            cand = ptr + SEL_BITS'(k);
            if (!found && req_valid[cand]) begin
                found = 1'b1;
                win   = cand;
            end
        end
    end

    always_comb begin
        grant = '0;
        if (free && found)
            grant[win] = 1'b1;
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            m_ar_valid <= 1'b0;
            ptr        <= '0;
        end else if (free) begin
            m_ar_valid <= found;
            if (found)
                ptr <= win;
        end
    end

    always_ff @(posedge clk) begin
        if (free && found)
            m_ar <= req[win];   // Held while m_ar_ready is low
    end

endmodule

`default_nettype wire

/* hw/stride_prefetcher_top.sv */
// Hit is a report only, no read data is returned; at most one slice hits per cycle
`default_nettype none
`timescale 1ns/1ps

`include "pf_macros.svh"

module stride_prefetcher_top (
    input  logic                     clk,
    input  logic                     resetN,
    input  logic                     flush,
    input  logic                     s_ar_valid,
    input  pf_pkg::ar_req_t          s_ar,
    output logic                     s_ar_ready,
    input  logic                     m_ar_ready,
    output logic                     m_ar_valid,
    output pf_pkg::ar_req_t          m_ar,
    output logic                     hit,
    output pf_pkg::ar_req_t          hit_req,
    input  logic [`PF_ADDR_BITS-1:0] bar,
    input  logic [`PF_ADDR_BITS-1:0] limit,
    input  logic [`PF_LOG_QUEUE:0]   window_size,
    input  logic [`PF_WDOG_BITS-1:0] wdog_div
);
    import pf_pkg::*;

    localparam int N = `PF_NUM_SLICES;

    logic [N-1:0]    dmd_strobe;
    logic [N-1:0]    busy;
    logic [N-1:0]    req_valid;
    logic [N-1:0]    grant;
    logic [N-1:0]    slice_hit;
    ar_req_t         dmd_req;
    ar_req_t [N-1:0] slice_req;
    ar_req_t [N-1:0] slice_hit_req;

    ar_dispatch u_dispatch (
        .clk        (clk),
        .resetN     (resetN),
        .s_ar_valid (s_ar_valid),
        .s_ar       (s_ar),
        .busy       (busy),
        .s_ar_ready (s_ar_ready),
        .dmd_strobe (dmd_strobe),
        .dmd_req    (dmd_req)
    );

    for (genvar i = 0; i < N; i++) begin : g_slice
        prefetch_slice u_slice (
            .clk         (clk),
            .resetN      (resetN),
            .flush       (flush),
            .dmd_strobe  (dmd_strobe[i]),
            .dmd_req     (dmd_req),
            .grant       (grant[i]),
            .bar         (bar),
            .limit       (limit),
            .window_size (window_size),
            .wdog_div    (wdog_div),
            .req_valid   (req_valid[i]),
            .req         (slice_req[i]),
            .busy        (busy[i]),
            .hit         (slice_hit[i]),
            .hit_req     (slice_hit_req[i])
        );
    end

    ar_arbiter u_arbiter (
        .clk        (clk),
        .resetN     (resetN),
        .req_valid  (req_valid),
        .req        (slice_req),
        .m_ar_ready (m_ar_ready),
        .grant      (grant),
        .m_ar_valid (m_ar_valid),
        .m_ar       (m_ar)
    );

    // Stale payload of idle slices is masked out
    always_comb begin
        hit     = |slice_hit;
        hit_req = '0;
        for (int i = 0; i < N; i++) begin
            if (slice_hit[i])
                hit_req = hit_req | slice_hit_req[i];
        end
    end

endmodule

`default_nettype wire

/* verification/stride_prefetcher_tb.sv */
// One demand in flight at a time; the idle timeout test waits three quiet watchdog periods
`default_nettype none
`timescale 1ns/1ps

`include "pf_macros.svh"

module stride_prefetcher_tb;
    import pf_pkg::*;

    localparam int PERIOD     = 20;
    localparam int RST_CYCLES = 5;
    localparam int N          = `PF_NUM_SLICES;
    localparam int WIN        = 4;
    localparam int WDOG_DIV   = 255;
    localparam int REQ_CYCLES = 100;   // Per phase of one demand
    localparam int NUM_REQS   = 48;
    localparam int RUN_CYCLES = NUM_REQS * 3 * REQ_CYCLES + 3 * (WDOG_DIV + 1) + 100;
    localparam int LEN_LIMIT  = (1 << `PF_LOG_QUEUE) / 2;

    logic                     clk;
    logic                     resetN;
    logic                     flush;
    logic                     s_ar_valid;
    logic                     s_ar_ready;
    logic                     m_ar_ready;
    logic                     m_ar_valid;
    logic                     hit;
    ar_req_t                  s_ar;
    ar_req_t                  m_ar;
    ar_req_t                  hit_req;
    logic [`PF_ADDR_BITS-1:0] bar;
    logic [`PF_ADDR_BITS-1:0] limit;
    logic [`PF_LOG_QUEUE:0]   window_size;
    logic [`PF_WDOG_BITS-1:0] wdog_div;

    // Expected stream context per slice
    slice_state_t             m_state  [N];
    logic [`PF_ID_BITS-1:0]   m_id     [N];
    logic [`PF_LEN_BITS-1:0]  m_len    [N];
    logic [`PF_ADDR_BITS-1:0] m_last   [N];
    logic [`PF_ADDR_BITS-1:0] m_stride [N];
    logic [`PF_ADDR_BITS-1:0] m_next   [N];
    logic [`PF_ADDR_BITS-1:0] m_tags   [N][$];

    ar_req_t cur;          // Demand in flight
    bit      cur_hit;
    bit      cur_fwd;
    bit      cur_done;
    int      xfer_edge;
    int      cycle = 0;
    int      errors = 0;
    int      err_mark = 0;
    int      tests = 0;
    logic    prev_valid = 1'b0;
    logic    prev_ready = 1'b0;
    ar_req_t prev_m_ar;

    stride_prefetcher_top DUT (
        .clk         (clk),
        .resetN      (resetN),
        .flush       (flush),
        .s_ar_valid  (s_ar_valid),
        .s_ar        (s_ar),
        .s_ar_ready  (s_ar_ready),
        .m_ar_ready  (m_ar_ready),
        .m_ar_valid  (m_ar_valid),
        .m_ar        (m_ar),
        .hit         (hit),
        .hit_req     (hit_req),
        .bar         (bar),
        .limit       (limit),
        .window_size (window_size),
        .wdog_div    (wdog_div)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // DDR side accepts at random
    always @(posedge clk) begin
        #2;
        m_ar_ready = ($urandom % 2) == 1;
    end

    task automatic clear_slice(input int sl);
        m_state[sl] = ST_IDLE;
        m_tags[sl].delete();
    endtask

    function automatic bit more_prefetch(input int sl);
        return m_state[sl] == ST_ACTIVE && m_tags[sl].size() < WIN
               && m_next[sl] >= bar && m_next[sl] <= limit;
    endfunction

    // Reference rules for one demand, returns whether it should hit
    task automatic predict(input ar_req_t r, output bit is_hit);
        int                       sl;
        int                       idx;
        bit                       learnable;
        bit                       miss;
        logic [`PF_ADDR_BITS-1:0] st;
        sl        = int'(r.id) % N;
        idx       = -1;
        learnable = int'(r.len) < LEN_LIMIT;
        st        = r.addr - m_last[sl];
        miss      = r.id != m_id[sl] || r.len != m_len[sl] || !learnable;
        is_hit    = 1'b0;
        case (m_state[sl])
            ST_IDLE: begin
                if (learnable) begin
                    m_state[sl] = ST_ARM;
                    m_id[sl]    = r.id;
                    m_len[sl]   = r.len;
                end
            end
            ST_ARM: begin
                if (miss) begin
                    clear_slice(sl);
                end else if (st != '0) begin
                    m_state[sl]  = ST_ACTIVE;
                    m_stride[sl] = st;
                    m_next[sl]   = r.addr + st;
                end
            end
            default: begin
                if (miss || st != m_stride[sl]) begin
                    clear_slice(sl);
                end else begin
                    for (int i = 0; i < m_tags[sl].size(); i++)
                        if (idx < 0 && m_tags[sl][i] == r.addr)
                            idx = i;
                    if (idx >= 0) begin
                        m_tags[sl].delete(idx);
                        is_hit = 1'b1;
                    end
                end
            end
        endcase
        m_last[sl] = r.addr;
    endtask

    task automatic log_transfer(input ar_req_t t);
        int sl;
        bit ok;
        sl = int'(t.id) % N;
        if (cur_fwd && !cur_done && t == cur) begin
            cur_done = 1'b1;
        end else begin
            ok = more_prefetch(sl) && t.id == m_id[sl] && t.len == m_len[sl];
            assert (ok) else begin
                $display("Unexpected request on m_ar: id %h addr %h len %h", t.id, t.addr, t.len);
                errors++;
            end
            if (ok) begin
                assert (t.addr == m_next[sl]) else begin
                    $display("CHECK FAILED m_ar.addr: got %h expected %h", t.addr, m_next[sl]);
                    errors++;
                end
                m_tags[sl].push_back(t.addr);
                m_next[sl] = t.addr + m_stride[sl];
            end
        end
    endtask

    task automatic check_hit(input ar_req_t h);
        assert (cur_hit && !cur_done) else begin
            $display("Hit reported for id %h addr %h with no demand due to hit", h.id, h.addr);
            errors++;
        end
        assert (h == cur) else begin
            $display("CHECK FAILED hit_req: got %h expected %h", h, cur);
            errors++;
        end
        assert (cycle + 1 == xfer_edge + 2) else begin
            $display("CHECK FAILED hit edge: got %h expected %h", cycle + 1, xfer_edge + 2);
            errors++;
        end
        cur_done = 1'b1;
    endtask

    // Outputs are sampled mid-cycle, where they are stable
    always @(negedge clk) begin
        if (cycle <= RST_CYCLES) begin   // During reset and the first cycle after release
            assert (!m_ar_valid) else begin
                $display("CHECK FAILED m_ar_valid: got %h expected 0", m_ar_valid);
                errors++;
            end
            assert (!hit) else begin
                $display("CHECK FAILED hit: got %h expected 0", hit);
                errors++;
            end
            assert (s_ar_ready) else begin
                $display("CHECK FAILED s_ar_ready: got %h expected 1", s_ar_ready);
                errors++;
            end
        end else begin
            if (prev_valid && !prev_ready) begin
                assert (m_ar_valid && m_ar == prev_m_ar) else begin
                    $display("CHECK FAILED m_ar: got %h expected %h", m_ar, prev_m_ar);
                    errors++;
                end
            end
            if (m_ar_valid && m_ar_ready)
                log_transfer(m_ar);
            if (hit)
                check_hit(hit_req);
        end
        prev_valid = m_ar_valid;
        prev_ready = m_ar_ready;
        prev_m_ar  = m_ar;
    end

    task automatic send_req(input logic [`PF_ID_BITS-1:0] id,
                            input logic [`PF_ADDR_BITS-1:0] addr,
                            input logic [`PF_LEN_BITS-1:0] len);
        ar_req_t r;
        bit      exp_hit;
        int      n;
        int      sl;
        r  = '{addr: addr, len: len, id: id};
        sl = int'(id) % N;
        n  = 0;
        @(posedge clk);
        #2;
        predict(r, exp_hit);
        cur        = r;
        cur_hit    = exp_hit;
        cur_fwd    = !exp_hit;
        cur_done   = 1'b0;
        s_ar       = r;
        s_ar_valid = 1'b1;
        @(negedge clk);
        while (!s_ar_ready && n < REQ_CYCLES) begin
            @(negedge clk);
            n++;
        end
        xfer_edge = cycle + 1;   // Transfer on the coming edge
        @(posedge clk);
        #2;
        s_ar_valid = 1'b0;
        n = 0;
        while (!cur_done && n < REQ_CYCLES) begin
            @(negedge clk);
            n++;
        end
        assert (cur_done) else begin
            $display("Demand id %h addr %h was neither forwarded nor hit", id, addr);
            errors++;
        end
        n = 0;
        while (more_prefetch(sl) && n < REQ_CYCLES) begin   // Let the window refill
            @(negedge clk);
            n++;
        end
        assert (!more_prefetch(sl)) else begin
            $display("Prefetch window of slice %0d (%s) never filled", sl, m_state[sl].name());
            errors++;
        end
        cur_fwd = 1'b0;
        cur_hit = 1'b0;
    endtask

    task automatic flush_all();
        @(posedge clk);
        #2;
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        for (int i = 0; i < N; i++)
            clear_slice(i);
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %-12s %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        #(longint'(RUN_CYCLES) * 2 * PERIOD);
        $display("Watchdog: the run did not finish in time");
        $display("Done: errors found");
        $finish;
    end

    initial begin
        void'($urandom(32'h6c36fcc5));
        resetN      = 1'b0;
        flush       = 1'b0;
        s_ar_valid  = 1'b0;
        s_ar        = '0;
        m_ar_ready  = 1'b0;
        bar         = 32'h1000;
        limit       = 32'h1fff;
        window_size = 4'(WIN);
        wdog_div    = 10'(WDOG_DIV);
        for (int i = 0; i < N; i++) begin
            clear_slice(i);
            m_id[i]   = '0;
            m_len[i]  = '0;
            m_last[i] = '0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        resetN = 1'b1;
        repeat (10) @(posedge clk);   // Any m_ar now is flagged by the monitor
        end_test("reset");

        flush_all();
        send_req(4'h1, 32'h1000, 8'h2);
        send_req(4'h1, 32'h1040, 8'h2);
        end_test("forwarding");

        for (int k = 2; k < 8; k++)
            send_req(4'h1, 32'h1000 + 32'(k) * 32'h40, 8'h2);
        flush_all();
        send_req(4'h5, 32'h1f00, 8'h1);   // Runs into limit
        send_req(4'h5, 32'h1f40, 8'h1);
        send_req(4'h5, 32'h1f80, 8'h1);
        end_test("learning");

        flush_all();
        send_req(4'h2, 32'h1000, 8'h1);
        send_req(4'h2, 32'h1080, 8'h1);
        send_req(4'h2, 32'h1100, 8'h1);
        send_req(4'h2, 32'h1200, 8'h1);   // Stride change
        send_req(4'h2, 32'h1280, 8'h1);
        send_req(4'h2, 32'h1300, 8'h1);
        send_req(4'h2, 32'h1380, 8'h0);   // Length change
        send_req(4'h2, 32'h1400, 8'h1);
        send_req(4'h2, 32'h1440, 8'h1);
        flush_all();
        send_req(4'h2, 32'h1480, 8'h1);
        send_req(4'h2, 32'h14c0, 8'h1);
        repeat (3 * (WDOG_DIV + 1) + 4) @(posedge clk);
        for (int i = 0; i < N; i++)
            clear_slice(i);
        send_req(4'h2, 32'h1500, 8'h1);
        end_test("cleanup");

        flush_all();
        for (int k = 0; k < 4; k++)
            send_req(4'h3, 32'h1000 + 32'(k) * 32'h100, 8'(LEN_LIMIT));
        end_test("long_burst");

        flush_all();
        for (int k = 0; k < 8; k++) begin
            send_req(4'h1, 32'h1000 + 32'(k) * 32'h40, 8'h2);
            send_req(4'h6, 32'h1800 + 32'(k) * 32'h80, 8'h3);
        end
        end_test("interleaved");

        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+hw
hw/pf_pkg.sv
hw/watchdog_timer.sv
hw/ar_dispatch.sv
hw/prefetch_slice.sv
hw/ar_arbiter.sv
hw/stride_prefetcher_top.sv
verification/stride_prefetcher_tb.sv

/* Makefile */
# Verilator build and run of the stride prefetcher testbench

VERILATOR ?= verilator
TOP       ?= stride_prefetcher_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= files.f
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
